//--- hw/xtouch_pkg.sv
// Widths and encodings are fixed by the touch command protocol and are not meant to be changed
`default_nettype none

package xtouch_pkg;

  // ----------------------------------------------------------
  // Protocol widths
  // ----------------------------------------------------------
  localparam int EA_W       = 64;            // Effective address
  localparam int CMD_ADDR_W = 68;            // Command address field

  typedef logic [EA_W-1:0]       ea_t;
  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [7:0]            opcode_t;
  typedef logic [3:0]            flag_t;
  typedef logic [15:0]           afutag_t;   // 2'b00, class, engine, slot
  typedef logic [5:0]            eng_num_t;
  typedef logic [11:0]           actag_t;
  typedef logic [15:0]           bdf_t;      // Bus 8, device 5, function 3

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  localparam opcode_t OP_XLATE_TOUCH   = 8'h78;
  localparam opcode_t OP_XLATE_TOUCH_N = 8'h79;

  localparam flag_t FLAG_LWT_WRITE = 4'h2;   // Lightweight write, no TA
  localparam flag_t FLAG_HWT_WRITE = 4'h6;   // Heavyweight write, no TA

  localparam logic [2:0] AFUTAG_CLASS = 3'b001;
  localparam logic [4:0] TAG_SOURCE   = 5'd2;
  localparam logic [4:0] TAG_DEST     = 5'd3;

  // One-hot sequencer states
  typedef enum logic [3:0] {
    MAIN_IDLE       = 4'b0001,
    MAIN_WT4GNT_SRC = 4'b0010,
    MAIN_WT4GNT_DST = 4'b0100,
    MAIN_WT4RSP     = 4'b1000
  } main_state_t;

  typedef enum logic [5:0] {
    RETRY_IDLE           = 6'b000001,
    RETRY_WT4BACKOFF_SRC = 6'b000010,
    RETRY_WT4GNT_SRC     = 6'b000100,
    RETRY_WT4BACKOFF_DST = 6'b001000,
    RETRY_WT4GNT_DST     = 6'b010000,
    RETRY_ABORT          = 6'b100000
  } retry_state_t;

endpackage

`default_nettype wire

//--- hw/xtouch_main_seq.sv
// Handles one touch sequence at a time; wait mode is latched one cycle late so hold it steady at start
`timescale 1ns/10ps
`default_nettype none

module xtouch_main_seq
  import xtouch_pkg::*;
(
  input  wire  clock,
  input  wire  rst_n,
  input  wire  start,
  input  wire  source_enable,
  input  wire  dest_enable,
  input  wire  wt4rsp_enable,
  input  wire  misc_gnt,
  input  wire  all_rsp_rcvd,
  output logic misc_req,
  output logic source_sent,
  output logic dest_sent,
  output logic done,
  output logic wt4rsp_enable_q,
  output logic idle,
  output logic error
);

  main_state_t state_q;
  main_state_t state_d;

  // ----------------------------------------------------------
  // Transition table
  // ----------------------------------------------------------
  always_comb
  begin
    state_d  = state_q;
    misc_req = 1'b0;
    done     = 1'b0;
    case (state_q)
      MAIN_IDLE:
        if (start)
        begin
          if (source_enable)
          begin
            state_d  = MAIN_WT4GNT_SRC;
            misc_req = 1'b1;
          end
          else if (dest_enable)
          begin
            state_d  = MAIN_WT4GNT_DST;
            misc_req = 1'b1;
          end
          else
            done = 1'b1;                           // Nothing enabled, finish at once
        end
      MAIN_WT4GNT_SRC:
        if (misc_gnt)
        begin
          if (dest_enable)
          begin
            state_d  = MAIN_WT4GNT_DST;              // Source out, ask again for dest
            misc_req = 1'b1;
          end
          else if (wt4rsp_enable_q)
            state_d = MAIN_WT4RSP;
          else
          begin
            state_d = MAIN_IDLE;
            done    = 1'b1;
          end
        end
      MAIN_WT4GNT_DST:
        if (misc_gnt)
        begin
          if (wt4rsp_enable_q)
            state_d = MAIN_WT4RSP;
          else
          begin
            state_d = MAIN_IDLE;
            done    = 1'b1;
          end
        end
      MAIN_WT4RSP:
        if (all_rsp_rcvd)
        begin
          state_d = MAIN_IDLE;                     // Scorecard balanced
          done    = 1'b1;
        end
      default:
        state_d = MAIN_IDLE;
    endcase
  end

  assign source_sent = (state_q == MAIN_WT4GNT_SRC) && misc_gnt;
  assign dest_sent   = (state_q == MAIN_WT4GNT_DST) && misc_gnt;
  assign idle        = (state_q == MAIN_IDLE);
  assign error       = !$onehot(state_q);          // Bad encoding, recover next cycle

  always_ff @(posedge clock)
  begin
    if (!rst_n || error)
      state_q <= MAIN_IDLE;
    else
      state_q <= state_d;
    if (!rst_n)
      wt4rsp_enable_q <= 1'b0;
    else
      wt4rsp_enable_q <= wt4rsp_enable;            // Mode register
  end

  // State must remain one-hot for every cycle out of reset
  a_state_onehot : assert property (@(posedge clock) disable iff (!rst_n) $onehot(state_q))
    else $error("main sequencer state not one-hot");

endmodule

`default_nettype wire

//--- hw/xtouch_retry_seq.sv
// One retry in flight; a start on both slots at once serves source and drops dest
`timescale 1ns/10ps
`default_nettype none

module xtouch_retry_seq
  import xtouch_pkg::*;
(
  input  wire  clock,
  input  wire  rst_n,
  input  wire  start_retry_source,
  input  wire  start_retry_dest,
  input  wire  retry_immediate,
  input  wire  retry_backoff,
  input  wire  retry_abort,
  input  wire  backoff_disable,
  input  wire  source_backoff_done,
  input  wire  dest_backoff_done,
  input  wire  retry_gnt,
  output logic retry_req,
  output logic retry_source_sent,
  output logic retry_dest_sent,
  output logic idle,
  output logic error
);

  retry_state_t state_q;
  retry_state_t state_d;
  logic         start_any;
  logic         slot_dst;
  logic         slot_done;
  logic         go_now;
  logic         go_wait;

  assign start_any = start_retry_source || start_retry_dest;
  assign slot_dst  = !start_retry_source;                          // Source has priority
  assign slot_done = slot_dst ? dest_backoff_done : source_backoff_done;
  assign go_now    = retry_immediate || (retry_backoff && backoff_disable);
  assign go_wait   = retry_backoff && !backoff_disable;

  // ----------------------------------------------------------
  // Transition table
  // ----------------------------------------------------------
  always_comb
  begin
    state_d   = state_q;
    retry_req = 1'b0;
    case (state_q)
      RETRY_IDLE:
        if (start_any)
        begin
          if (go_now || (go_wait && slot_done))
          begin
            state_d   = slot_dst ? RETRY_WT4GNT_DST : RETRY_WT4GNT_SRC;
            retry_req = 1'b1;                      // Timer not needed or already expired
          end
          else if (go_wait)
            state_d = slot_dst ? RETRY_WT4BACKOFF_DST : RETRY_WT4BACKOFF_SRC;
          else if (retry_abort)
            state_d = RETRY_ABORT;
        end
      RETRY_WT4BACKOFF_SRC:
        if (source_backoff_done)
        begin
          state_d   = RETRY_WT4GNT_SRC;
          retry_req = 1'b1;
        end
      RETRY_WT4BACKOFF_DST:
        if (dest_backoff_done)
        begin
          state_d   = RETRY_WT4GNT_DST;
          retry_req = 1'b1;
        end
      RETRY_WT4GNT_SRC, RETRY_WT4GNT_DST:
        if (retry_gnt)
          state_d = RETRY_IDLE;                    // Command goes out in the grant cycle
      RETRY_ABORT:
        state_d = RETRY_IDLE;                      // Single cycle, no request
      default:
        state_d = RETRY_IDLE;
    endcase
  end

  assign retry_source_sent = (state_q == RETRY_WT4GNT_SRC) && retry_gnt;
  assign retry_dest_sent   = (state_q == RETRY_WT4GNT_DST) && retry_gnt;
  assign idle              = (state_q == RETRY_IDLE);
  assign error             = !$onehot(state_q);

  always_ff @(posedge clock)
  begin
    if (!rst_n || error)
      state_q <= RETRY_IDLE;
    else
      state_q <= state_d;
  end

  // Response decoder gives at most one retry class per start
  a_one_class : assert property (@(posedge clock) disable iff (!rst_n)
    (idle && start_any) |-> $onehot0({retry_immediate, retry_backoff, retry_abort}))
    else $error("more than one retry class at start");

endmodule

`default_nettype wire

//--- hw/xtouch_scorecard.sv
// Counts main-path touches only; retried commands and their responses are outside this record
`timescale 1ns/10ps
`default_nettype none

module xtouch_scorecard
(
  input  wire  clock,
  input  wire  rst_n,
  input  wire  wt4rsp_enable_q,
  input  wire  source_sent,
  input  wire  dest_sent,
  input  wire  source_rsp,
  input  wire  dest_rsp,
  input  wire  clear,
  output logic all_rsp_rcvd
);

  logic [1:0] sent_q;                // Bit 1 dest, bit 0 source
  logic [1:0] rcvd_q;

  // ----------------------------------------------------------
  // Sent and received masks
  // ----------------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (!rst_n || clear)
    begin
      sent_q <= 2'b00;
      rcvd_q <= 2'b00;
    end
    else if (wt4rsp_enable_q)        // Only tracked in wait mode
    begin
      sent_q <= sent_q | {dest_sent, source_sent};
      rcvd_q <= rcvd_q | {dest_rsp, source_rsp};
    end
  end

  // Registered view, so balance shows one cycle after the last response
  assign all_rsp_rcvd = (sent_q == rcvd_q);

  // A response must follow a command that the main sequencer really issued
  a_rsp_after_send : assert property (@(posedge clock) disable iff (!rst_n)
    wt4rsp_enable_q |-> (({dest_rsp, source_rsp} & ~sent_q) == 2'b00))
    else $error("response for a slot that was never sent");

endmodule

`default_nettype wire

//--- hw/xtouch_cmd_format.sv
// Purely combinational; expects at most one send pulse per cycle since the arbiter grants one path
`timescale 1ns/10ps
`default_nettype none

module xtouch_cmd_format
  import xtouch_pkg::*;
(
  input  wire           source_sent,
  input  wire           dest_sent,
  input  wire           retry_source_sent,
  input  wire           retry_dest_sent,
  input  wire           touch_n,
  input  wire           hwt,
  input  wire           retry_hwt,
  input  wire ea_t      source_ea,
  input  wire ea_t      dest_ea,
  input  wire eng_num_t eng_num,
  input  wire actag_t   actag,
  input  wire bdf_t     bdf,
  output logic          cmd_valid,
  output opcode_t       cmd_opcode,
  output actag_t        cmd_actag,
  output cmd_addr_t     cmd_addr,
  output afutag_t       cmd_afutag,
  output flag_t         cmd_flag,
  output bdf_t          cmd_bdf
);

  logic main_any;
  logic retry_any;
  logic src_slot;
  ea_t  sel_ea;

  assign main_any  = source_sent || dest_sent;
  assign retry_any = retry_source_sent || retry_dest_sent;
  assign src_slot  = source_sent || retry_source_sent;
  assign sel_ea    = src_slot ? source_ea : dest_ea;

  // ----------------------------------------------------------
  // Command fields, zero outside a send cycle
  // ----------------------------------------------------------
  always_comb
  begin
    cmd_valid  = main_any || retry_any;
    cmd_opcode = '0;
    cmd_actag  = '0;
    cmd_addr   = '0;
    cmd_afutag = '0;
    cmd_flag   = '0;
    cmd_bdf    = '0;
    if (cmd_valid)
    begin
      cmd_opcode = touch_n ? OP_XLATE_TOUCH_N : OP_XLATE_TOUCH;
      cmd_actag  = actag;
      cmd_addr   = {{(CMD_ADDR_W-EA_W){1'b0}}, sel_ea};      // EA zero-extended
      cmd_afutag = {2'b00, AFUTAG_CLASS, eng_num, src_slot ? TAG_SOURCE : TAG_DEST};
      if (main_any)
        cmd_flag = hwt ? FLAG_HWT_WRITE : FLAG_LWT_WRITE;    // First issue
      else
        cmd_flag = retry_hwt ? FLAG_HWT_WRITE : FLAG_LWT_WRITE;
      cmd_bdf    = bdf;
    end
  end

  // Main and retry grants never overlap
  always_comb
  begin
    a_one_send : assert #0 ($countones({source_sent, dest_sent,
                                        retry_source_sent, retry_dest_sent}) <= 1)
      else $error("more than one send pulse in a cycle");
  end

endmodule

`default_nettype wire

//--- hw/xtouch_engine.sv
// Main and retry paths share one command bus; the arbiter must never grant both in one cycle
`timescale 1ns/10ps
`default_nettype none

module xtouch_engine
  import xtouch_pkg::*;
(
  input  wire           clock,
  input  wire           rst_n,
  // Modes
  input  wire           source_enable,
  input  wire           dest_enable,
  input  wire           wt4rsp_enable,
  input  wire           touch_n,
  input  wire           hwt,
  input  wire           backoff_disable,
  // Main sequencer
  input  wire           start,
  input  wire           misc_gnt,
  input  wire           source_rsp,
  input  wire           dest_rsp,
  // Retry sequencer
  input  wire           start_retry_source,
  input  wire           start_retry_dest,
  input  wire           retry_immediate,
  input  wire           retry_backoff,
  input  wire           retry_abort,
  input  wire           retry_hwt,
  input  wire           source_backoff_done,
  input  wire           dest_backoff_done,
  input  wire           retry_gnt,
  // Addresses and identity
  input  wire ea_t      source_ea,
  input  wire ea_t      dest_ea,
  input  wire eng_num_t eng_num,
  input  wire actag_t   actag,
  input  wire bdf_t     bdf,
  // Status
  output wire           misc_req,
  output wire           retry_req,
  output wire           done,
  output wire           main_idle,
  output wire           retry_idle,
  output wire           main_error,
  output wire           retry_error,
  // Command bus
  output wire           cmd_valid,
  output wire opcode_t  cmd_opcode,
  output wire actag_t   cmd_actag,
  output wire cmd_addr_t cmd_addr,
  output wire afutag_t  cmd_afutag,
  output wire flag_t    cmd_flag,
  output wire bdf_t     cmd_bdf
);

  wire source_sent;          // Main path send pulses
  wire dest_sent;
  wire retry_source_sent;
  wire retry_dest_sent;
  wire wt4rsp_enable_q;
  wire all_rsp_rcvd;

  xtouch_main_seq main_seq_i (
    .clock(clock), .rst_n(rst_n), .start(start),
    .source_enable(source_enable), .dest_enable(dest_enable),
    .wt4rsp_enable(wt4rsp_enable), .misc_gnt(misc_gnt), .all_rsp_rcvd(all_rsp_rcvd),
    .misc_req(misc_req), .source_sent(source_sent), .dest_sent(dest_sent),
    .done(done), .wt4rsp_enable_q(wt4rsp_enable_q), .idle(main_idle), .error(main_error)
  );

  xtouch_retry_seq retry_seq_i (
    .clock(clock), .rst_n(rst_n),
    .start_retry_source(start_retry_source), .start_retry_dest(start_retry_dest),
    .retry_immediate(retry_immediate), .retry_backoff(retry_backoff),
    .retry_abort(retry_abort), .backoff_disable(backoff_disable),
    .source_backoff_done(source_backoff_done), .dest_backoff_done(dest_backoff_done),
    .retry_gnt(retry_gnt), .retry_req(retry_req),
    .retry_source_sent(retry_source_sent), .retry_dest_sent(retry_dest_sent),
    .idle(retry_idle), .error(retry_error)
  );

  // Cleared by done so each sequence starts balanced
  xtouch_scorecard scorecard_i (
    .clock(clock), .rst_n(rst_n), .wt4rsp_enable_q(wt4rsp_enable_q),
    .source_sent(source_sent), .dest_sent(dest_sent),
    .source_rsp(source_rsp), .dest_rsp(dest_rsp), .clear(done),
    .all_rsp_rcvd(all_rsp_rcvd)
  );

  xtouch_cmd_format cmd_format_i (
    .source_sent(source_sent), .dest_sent(dest_sent),
    .retry_source_sent(retry_source_sent), .retry_dest_sent(retry_dest_sent),
    .touch_n(touch_n), .hwt(hwt), .retry_hwt(retry_hwt),
    .source_ea(source_ea), .dest_ea(dest_ea), .eng_num(eng_num),
    .actag(actag), .bdf(bdf), .cmd_valid(cmd_valid), .cmd_opcode(cmd_opcode),
    .cmd_actag(cmd_actag), .cmd_addr(cmd_addr), .cmd_afutag(cmd_afutag),
    .cmd_flag(cmd_flag), .cmd_bdf(cmd_bdf)
  );

endmodule

`default_nettype wire

//--- bench/xtouch_model.svh
// Include inside the testbench module only, after fail_stop and the DUT signals are declared
`ifndef XTOUCH_MODEL_SVH
`define XTOUCH_MODEL_SVH

// ------------------------------------------------------------
// Expected fields from the protocol encodings
// ------------------------------------------------------------
function automatic opcode_t exp_opcode(logic n);
  return n ? 8'h79 : 8'h78;                 // xlate_touch.n or xlate_touch
endfunction

function automatic flag_t exp_flag(logic heavy);
  return heavy ? 4'h6 : 4'h2;               // Heavyweight or lightweight write
endfunction

// Two zero bits, class 001, engine, slot code
function automatic afutag_t exp_afutag(eng_num_t eng, logic is_src);
  return {2'b00, 3'b001, eng, is_src ? 5'd2 : 5'd3};
endfunction

// ------------------------------------------------------------
// Compare tasks, one per result type
// ------------------------------------------------------------
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_addr(input string name, input cmd_addr_t got, input cmd_addr_t exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_afutag(input string name, input afutag_t got, input afutag_t exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_flag(input string name, input flag_t got, input flag_t exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_actag(input string name, input actag_t got, input actag_t exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

task automatic check_bdf(input string name, input bdf_t got, input bdf_t exp);
  if (got !== exp)
    fail_stop($sformatf("ERR %s got %h expected %h", name, got, exp));
endtask

// Full command in a grant cycle
task automatic check_cmd(input logic is_src, input logic heavy);
  check_bit("cmd_valid", cmd_valid, 1'b1);
  check_opcode("cmd_opcode", cmd_opcode, exp_opcode(touch_n));
  check_actag("cmd_actag", cmd_actag, actag);
  check_addr("cmd_addr", cmd_addr, {4'h0, (is_src ? source_ea : dest_ea)});   // Zero-extended
  check_afutag("cmd_afutag", cmd_afutag, exp_afutag(eng_num, is_src));
  check_flag("cmd_flag", cmd_flag, exp_flag(heavy));
  check_bdf("cmd_bdf", cmd_bdf, bdf);
endtask

// No command on the bus, fields held at zero
task automatic check_quiet();
  check_bit("cmd_valid", cmd_valid, 1'b0);
  check_opcode("cmd_opcode", cmd_opcode, 8'h00);
  check_actag("cmd_actag", cmd_actag, 12'h000);
  check_addr("cmd_addr", cmd_addr, '0);
  check_afutag("cmd_afutag", cmd_afutag, 16'h0000);
  check_flag("cmd_flag", cmd_flag, 4'h0);
  check_bdf("cmd_bdf", cmd_bdf, 16'h0000);
endtask

`endif

//--- bench/xtouch_tb.sv
// Runs main and retry operations one at a time, so the two grant paths never overlap
`timescale 1ns/10ps
`default_nettype none

module xtouch_tb
  import xtouch_pkg::*;
();

  localparam int NUM_OPS     = 200;
  localparam int WATCHDOG_NS = (NUM_OPS * 40 + 10) * 10;   // 40 cycles per operation

  logic clock = 1'b0;
  logic rst_n;
  logic source_enable, dest_enable, wt4rsp_enable, touch_n, hwt, backoff_disable;
  logic start, misc_gnt;
  logic source_rsp = 1'b0;                  // Owned by the responder
  logic dest_rsp   = 1'b0;
  logic start_retry_source, start_retry_dest;
  logic retry_immediate, retry_backoff, retry_abort, retry_hwt;
  logic source_backoff_done, dest_backoff_done, retry_gnt;
  ea_t      source_ea, dest_ea;
  eng_num_t eng_num;
  actag_t   actag;
  bdf_t     bdf;
  wire misc_req, retry_req, done, main_idle, retry_idle, main_error, retry_error;
  wire cmd_valid;
  wire opcode_t   cmd_opcode;
  wire actag_t    cmd_actag;
  wire cmd_addr_t cmd_addr;
  wire afutag_t   cmd_afutag;
  wire flag_t     cmd_flag;
  wire bdf_t      cmd_bdf;

  logic [31:0] lfsr_q   = 32'd84389;
  int          cyc      = 0;               // Cycle index, bumped at each drive point
  int          src_wait = 0;               // Responder countdowns, 0 when idle
  int          dst_wait = 0;
  int          last_rsp = 0;               // Cycle of the latest response pulse

  xtouch_engine xtouch_engine_i (.*);

  always #5 clock = ~clock;

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  `include "xtouch_model.svh"

  // ------------------------------------------------------------
  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  // ------------------------------------------------------------
  function automatic logic rand_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = b ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    return b;
  endfunction

  function automatic int rand_int(int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++)
      v = (v << 1) | int'(rand_bit());
    return v;
  endfunction

  function automatic ea_t rand_ea();
    ea_t v;
    int  i;
    v = '0;
    for (i = 0; i < EA_W; i++)
      v = {v[EA_W-2:0], rand_bit()};
    return v;
  endfunction

  // Drive point 1 ns after the edge; one-cycle pulses drop here
  task automatic begin_cycle();
    @(posedge clock);
    #1;
    start              = 1'b0;
    misc_gnt           = 1'b0;
    retry_gnt          = 1'b0;
    start_retry_source = 1'b0;
    start_retry_dest   = 1'b0;
    retry_immediate    = 1'b0;
    retry_backoff      = 1'b0;
    retry_abort        = 1'b0;
  endtask

  task automatic settle();
    #3;                                     // Outputs stable well before the next edge
    check_bit("main_error", main_error, 1'b0);
    check_bit("retry_error", retry_error, 1'b0);
  endtask

  // Responder: pulses a slot's response when its countdown reaches 1
  always @(posedge clock)
  begin
    #1;
    cyc        = cyc + 1;
    source_rsp = (src_wait == 1);
    dest_rsp   = (dst_wait == 1);
    if (source_rsp || dest_rsp)
      last_rsp = cyc;
    if (src_wait > 0)
      src_wait = src_wait - 1;
    if (dst_wait > 0)
      dst_wait = dst_wait - 1;
  end

  // ------------------------------------------------------------
  // Main touch: source then dest, arbiter grants after 1 to 4 cycles
  // ------------------------------------------------------------
  task automatic main_op();
    int   s;
    int   d;
    logic is_src;
    logic seen;
    begin_cycle();                          // Modes settle one cycle ahead of start
    source_enable = rand_bit();
    dest_enable   = rand_bit();
    wt4rsp_enable = rand_bit();
    touch_n       = rand_bit();
    hwt           = rand_bit();
    source_ea     = rand_ea();
    dest_ea       = rand_ea();
    eng_num       = eng_num_t'(rand_int(6));
    actag         = actag_t'(rand_int(12));
    bdf           = bdf_t'(rand_int(16));
    settle();
    check_bit("main_idle", main_idle, 1'b1);
    check_quiet();
    begin_cycle();
    start = 1'b1;
    settle();
    check_bit("misc_req", misc_req, source_enable || dest_enable);
    check_bit("done", done, !(source_enable || dest_enable));   // Nothing enabled
    for (s = 0; s < 2; s++)
    begin
      is_src = (s == 0);
      if (is_src ? source_enable : dest_enable)
      begin
        d = 1 + rand_int(2);
        repeat (d - 1)
        begin
          begin_cycle();
          settle();
          check_bit("cmd_valid", cmd_valid, 1'b0);
          check_bit("misc_req", misc_req, 1'b0);   // No repeated request
          check_bit("done", done, 1'b0);
        end
        begin_cycle();
        misc_gnt = 1'b1;
        settle();
        check_cmd(is_src, hwt);
        check_bit("misc_req", misc_req, is_src && dest_enable);
        check_bit("done", done, !wt4rsp_enable && !(is_src && dest_enable));
        if (wt4rsp_enable && is_src)
          src_wait = 1 + rand_int(3) % 5;
        else if (wt4rsp_enable)
          dst_wait = 1 + rand_int(3) % 5;
      end
    end
    seen = !(wt4rsp_enable && (source_enable || dest_enable));
    while (!seen)
    begin
      begin_cycle();
      settle();
      seen = (src_wait == 0) && (dst_wait == 0) && (cyc == last_rsp + 1);
      check_quiet();                       // No further command while waiting
      check_bit("misc_req", misc_req, 1'b0);
      check_bit("done", done, seen);       // Exactly one cycle after the last response
    end
  endtask

  // ------------------------------------------------------------
  // Retry: immediate, backoff or abort on one slot
  // ------------------------------------------------------------
  task automatic retry_op();
    int   cls;
    int   sel;
    int   delay;
    int   c;
    int   d;
    logic is_src;
    logic pending;
    begin_cycle();
    backoff_disable     = rand_bit();
    retry_hwt           = rand_bit();
    source_backoff_done = 1'b0;
    dest_backoff_done   = 1'b0;
    cls     = rand_int(2) % 3;              // 0 immediate, 1 backoff, 2 abort
    sel     = rand_int(2) % 3;              // 0 source, 1 dest, 2 both
    delay   = rand_int(3) % 7;
    is_src  = (sel != 1);                   // Both at once takes source
    pending = (cls == 1) && !backoff_disable && (delay != 0);
    settle();
    check_bit("retry_idle", retry_idle, 1'b1);
    check_quiet();
    begin_cycle();
    start_retry_source = (sel != 1);
    start_retry_dest   = (sel != 0);
    retry_immediate    = (cls == 0);
    retry_backoff      = (cls == 1);
    retry_abort        = (cls == 2);
    if (is_src)
      source_backoff_done = (delay == 0);
    else
      dest_backoff_done = (delay == 0);
    settle();
    check_bit("retry_req", retry_req, (cls != 2) && !pending);
    if (cls == 2)
    begin
      begin_cycle();
      settle();
      check_bit("retry_idle", retry_idle, 1'b0);   // One cycle in ABORT
      check_bit("retry_req", retry_req, 1'b0);
      check_quiet();
      begin_cycle();
      settle();
      check_bit("retry_idle", retry_idle, 1'b1);
      check_bit("retry_req", retry_req, 1'b0);
    end
    else
    begin
      if (pending)
        for (c = 1; c <= delay; c++)
        begin
          begin_cycle();
          if (is_src)
            source_backoff_done = (c == delay);    // Stays high once set
          else
            dest_backoff_done = (c == delay);
          settle();
          check_quiet();
          check_bit("retry_req", retry_req, c == delay);
        end
      d = 1 + rand_int(2);
      repeat (d - 1)
      begin
        begin_cycle();
        settle();
        check_bit("cmd_valid", cmd_valid, 1'b0);
        check_bit("retry_req", retry_req, 1'b0);
      end
      begin_cycle();
      retry_gnt = 1'b1;
      settle();
      check_cmd(is_src, retry_hwt);
      begin_cycle();
      settle();
      check_bit("retry_idle", retry_idle, 1'b1);
      check_quiet();                               // Dest of a double start is dropped
    end
  endtask

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------
  initial
  begin
    int op;
    rst_n = 1'b0;
    {source_enable, dest_enable, wt4rsp_enable, touch_n, hwt, backoff_disable} = '0;
    {start, misc_gnt, start_retry_source, start_retry_dest} = '0;
    {retry_immediate, retry_backoff, retry_abort, retry_hwt} = '0;
    {source_backoff_done, dest_backoff_done, retry_gnt} = '0;
    source_ea = '0;
    dest_ea   = '0;
    eng_num   = '0;
    actag     = '0;
    bdf       = '0;
    repeat (4) @(posedge clock);
    #1 rst_n = 1'b1;
    settle();
    check_bit("misc_req", misc_req, 1'b0);
    check_bit("retry_req", retry_req, 1'b0);
    check_bit("cmd_valid", cmd_valid, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("main_idle", main_idle, 1'b1);
    check_bit("retry_idle", retry_idle, 1'b1);
    for (op = 0; op < NUM_OPS; op++)
      if (rand_bit())
        main_op();
      else
        retry_op();
    $display("TEST PASS");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    fail_stop("watchdog expired before all operations finished");
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+bench
hw/xtouch_pkg.sv
hw/xtouch_main_seq.sv
hw/xtouch_retry_seq.sv
hw/xtouch_scorecard.sv
hw/xtouch_cmd_format.sv
hw/xtouch_engine.sv
bench/xtouch_tb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module xtouch_tb -f vlog.f

run: build
	./obj_dir/Vxtouch_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAIL" sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only -Wall --top-module xtouch_engine -f vlog.f

clean:
	rm -rf obj_dir sim.log
